//--- rtl/imul_pkg.sv
//--------------------
// Shared widths and message types of the iterative multiplier
// Only the low half of the product is carried, so signedness does not matter
//--------------------

package imul_pkg;

  // Operand and result width in bits
  localparam int imul_nbits = 32;

  // Shift counter width, must hold imul_nbits
  localparam int imul_count_nbits = 6;

  //--------------------
  // Messages
  //--------------------

  // Request payload, 64 bits
  typedef struct packed {
    logic [imul_nbits-1:0] a;
    logic [imul_nbits-1:0] b;
  } imul_req_msg_t;

  // Response payload, low 32 bits of a*b
  typedef struct packed {
    logic [imul_nbits-1:0] result;
  } imul_resp_msg_t;

  //--------------------
  // Control and status
  //--------------------

  // Control word, ctrl to dpath
  typedef struct packed {
    logic result_en;       // Result register write enable
    logic a_mux_sel;       // 1 loads A from request
    logic b_mux_sel;       // 1 loads B from request
    logic result_mux_sel;  // 1 clears result
    logic add_mux_sel;     // 1 keeps old result, 0 takes sum
  } imul_cs_t;

  // Status word, dpath to ctrl
  typedef struct packed {
    logic b_lsb;           // Bit 0 of B register
  } imul_ss_t;

endpackage

//--- rtl/imul_msg_queue.sv
//--------------------
// Two-entry valid/ready queue, one cycle of latency
// Output taken from storage, no combinational path from enq to deq
//--------------------

module imul_msg_queue #(
  parameter type msg_t = logic [31:0]
) (
  input  logic clk,
  input  logic reset,

  // Enqueue side
  input  logic enq_val,
  output logic enq_rdy,
  input  msg_t enq_msg,

  // Dequeue side
  output logic deq_val,
  input  logic deq_rdy,
  output msg_t deq_msg
);

  //--------------------
  // Storage and pointers
  //--------------------

  msg_t       entries [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;

  logic enq_go;
  logic deq_go;

  // Ready whenever a slot is free
  assign enq_rdy = (count != 2'd2);
  assign deq_val = (count != 2'd0);
  assign deq_msg = entries[rd_ptr];

  assign enq_go = enq_val && enq_rdy;
  assign deq_go = deq_val && deq_rdy;

  // Payload write, no reset on storage
  always_ff @(posedge clk) begin
    if (enq_go) begin
      entries[wr_ptr] <= enq_msg;
    end
  end

  //--------------------
  // Pointer and count update
  //--------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (enq_go) begin
        wr_ptr <= ~wr_ptr;
      end
      if (deq_go) begin
        rd_ptr <= ~rd_ptr;
      end
      // Simultaneous enq and deq leaves count unchanged
      case ({enq_go, deq_go})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- rtl/imul_dpath.sv
//--------------------
// Shift-and-add datapath, one multiplier bit per cycle
// A and B load every cycle the control word selects, no enables on them
//--------------------

module imul_dpath (
  input  logic                     clk,
  input  logic                     reset,

  // Message data
  input  imul_pkg::imul_req_msg_t  req_msg,
  output imul_pkg::imul_resp_msg_t resp_msg,

  // Control in, status out
  input  imul_pkg::imul_cs_t       cs,
  output imul_pkg::imul_ss_t       ss
);

  import imul_pkg::*;

  //--------------------
  // Datapath signals
  //--------------------

  logic [imul_nbits-1:0] a_reg;
  logic [imul_nbits-1:0] b_reg;
  logic [imul_nbits-1:0] result_reg;

  logic [imul_nbits-1:0] a_mux_out;
  logic [imul_nbits-1:0] b_mux_out;
  logic [imul_nbits-1:0] a_shift_out;
  logic [imul_nbits-1:0] b_shift_out;
  logic [imul_nbits-1:0] sum;
  logic [imul_nbits-1:0] add_mux_out;
  logic [imul_nbits-1:0] result_mux_out;

  //--------------------
  // Operand path
  //--------------------

  // A moves up one place per step
  assign a_shift_out = a_reg << 1;

  // B moves down, its lsb drives the add decision
  assign b_shift_out = b_reg >> 1;

  // Request operands or shifted values
  assign a_mux_out = cs.a_mux_sel ? req_msg.a : a_shift_out;
  assign b_mux_out = cs.b_mux_sel ? req_msg.b : b_shift_out;

  always_ff @(posedge clk) begin
    a_reg <= a_mux_out;
    b_reg <= b_mux_out;
  end

  //--------------------
  // Accumulator path
  //--------------------

  // Partial product added to running result
  assign sum = result_reg + a_reg;

  // Hold when B lsb is zero
  assign add_mux_out = cs.add_mux_sel ? result_reg : sum;

  // Zero at the start of a new multiply
  assign result_mux_out = cs.result_mux_sel ? '0 : add_mux_out;

  always_ff @(posedge clk) begin
    if (reset) begin
      result_reg <= '0;
    end else if (cs.result_en) begin
      result_reg <= result_mux_out;
    end
  end

  //--------------------
  // Outputs
  //--------------------

  assign ss.b_lsb = b_reg[0];

  // Result register is the response, valid only in DONE
  assign resp_msg.result = result_reg;

endmodule

//--- rtl/imul_ctrl.sv
//--------------------
// IDLE/CALC/DONE control, fixed 32 shift cycles per multiply
// Holds one item at a time, no early exit on zero bits
//--------------------

module imul_ctrl (
  input  logic               clk,
  input  logic               reset,

  // Core handshake
  input  logic               req_val,
  output logic               req_rdy,
  output logic               resp_val,
  input  logic               resp_rdy,

  // Control out, status in
  output imul_pkg::imul_cs_t cs,
  input  imul_pkg::imul_ss_t ss
);

  import imul_pkg::*;

  //--------------------
  // State
  //--------------------

  typedef enum logic [1:0] {
    STATE_IDLE,
    STATE_CALC,
    STATE_DONE
  } state_t;

  state_t state_reg;
  state_t state_next;

  logic [imul_count_nbits-1:0] counter;

  logic req_go;
  logic resp_go;
  logic is_calc_done;

  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // Last of the imul_nbits shift cycles
  assign is_calc_done = (counter == imul_count_nbits'(imul_nbits - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state_reg <= STATE_IDLE;
    end else begin
      state_reg <= state_next;
    end
  end

  // Cleared on accept, one step per CALC cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      counter <= '0;
    end else if (state_reg == STATE_IDLE && req_go) begin
      counter <= '0;
    end else if (state_reg == STATE_CALC) begin
      counter <= counter + 1'b1;
    end
  end

  //--------------------
  // Transitions
  //--------------------

  always_comb begin
    state_next = state_reg;
    case (state_reg)
      STATE_IDLE: if (req_go) state_next = STATE_CALC;
      STATE_CALC: if (is_calc_done) state_next = STATE_DONE;
      STATE_DONE: if (resp_go) state_next = STATE_IDLE;
      default:    state_next = STATE_IDLE;
    endcase
  end

  //--------------------
  // Control word table
  //--------------------

  // Columns: rdy val | result_en a_sel b_sel result_sel add_sel
  always_comb begin
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    cs       = '{result_en: 1'b0, a_mux_sel: 1'b0, b_mux_sel: 1'b0,
                 result_mux_sel: 1'b0, add_mux_sel: 1'b1};
    case (state_reg)
      // Load operands, clear result
      STATE_IDLE: begin
        req_rdy = 1'b1;
        cs      = '{result_en: 1'b1, a_mux_sel: 1'b1, b_mux_sel: 1'b1,
                    result_mux_sel: 1'b1, add_mux_sel: 1'b0};
      end
      STATE_CALC: begin
        if (ss.b_lsb) begin
          // Add and shift
          cs = '{result_en: 1'b1, a_mux_sel: 1'b0, b_mux_sel: 1'b0,
                 result_mux_sel: 1'b0, add_mux_sel: 1'b0};
        end else begin
          // Shift only, result held through add mux
          cs = '{result_en: 1'b1, a_mux_sel: 1'b0, b_mux_sel: 1'b0,
                 result_mux_sel: 1'b0, add_mux_sel: 1'b1};
        end
      end
      // Result frozen until consumer takes it
      STATE_DONE: begin
        resp_val = 1'b1;
      end
      default: begin
        req_rdy  = 1'b0;
        resp_val = 1'b0;
      end
    endcase
  end

endmodule

//--- rtl/imul_top.sv
//--------------------
// Multiplier with request and response queues
// Up to five items in flight, latency varies with back-pressure
//--------------------

module imul_top (
  input  logic                     clk,
  input  logic                     reset,

  // Request side
  input  logic                     req_val,
  output logic                     req_rdy,
  input  imul_pkg::imul_req_msg_t  req_msg,

  // Response side
  output logic                     resp_val,
  input  logic                     resp_rdy,
  output imul_pkg::imul_resp_msg_t resp_msg
);

  import imul_pkg::*;

  //--------------------
  // Internal wires
  //--------------------

  // Request queue to core
  logic           core_req_val;
  logic           core_req_rdy;
  imul_req_msg_t  core_req_msg;

  // Core to response queue
  logic           core_resp_val;
  logic           core_resp_rdy;
  imul_resp_msg_t core_resp_msg;

  imul_cs_t cs;
  imul_ss_t ss;

  imul_msg_queue #(.msg_t(imul_req_msg_t)) req_queue (
    .clk     (clk),
    .reset   (reset),
    .enq_val (req_val),
    .enq_rdy (req_rdy),
    .enq_msg (req_msg),
    .deq_val (core_req_val),
    .deq_rdy (core_req_rdy),
    .deq_msg (core_req_msg)
  );

  //--------------------
  // Multiplier core
  //--------------------

  imul_ctrl ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (core_req_val),
    .req_rdy  (core_req_rdy),
    .resp_val (core_resp_val),
    .resp_rdy (core_resp_rdy),
    .cs       (cs),
    .ss       (ss)
  );

  // Operands taken straight from request queue head
  imul_dpath dpath (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (core_req_msg),
    .resp_msg (core_resp_msg),
    .cs       (cs),
    .ss       (ss)
  );

  imul_msg_queue #(.msg_t(imul_resp_msg_t)) resp_queue (
    .clk     (clk),
    .reset   (reset),
    .enq_val (core_resp_val),
    .enq_rdy (core_resp_rdy),
    .enq_msg (core_resp_msg),
    .deq_val (resp_val),
    .deq_rdy (resp_rdy),
    .deq_msg (resp_msg)
  );

endmodule

//--- tb/imul_tb.sv
//--------------------
// Directed testbench for imul_top, responses checked in request order
// Operands from a 32-bit LFSR, expected results from a 64-bit software product
//--------------------

module imul_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import imul_pkg::*;

  //--------------------
  // Test sizes and limits
  //--------------------

  localparam int clk_period     = 20;
  localparam int n_directed     = 10;
  localparam int n_random       = 40;
  localparam int n_stall_max    = 5;
  localparam int n_toggle       = 30;
  localparam int stall_cycles   = 200;
  // Generous bound per item, core alone needs 35 cycles
  localparam int item_cycles    = 120;
  localparam int total_items    = n_directed + n_random + n_stall_max + n_toggle;
  localparam int watchdog_ns    = (total_items * item_cycles + stall_cycles + 100) * clk_period;

  logic           clk;
  logic           reset;
  logic           req_val;
  logic           req_rdy;
  imul_req_msg_t  req_msg;
  logic           resp_val;
  logic           resp_rdy;
  imul_resp_msg_t resp_msg;

  logic [31:0] lfsr_state;
  logic [31:0] expected_q [$];
  logic [31:0] op_a [64];
  logic [31:0] op_b [64];
  int          error_count;
  int          check_count;
  int          tests_run;

  imul_top UUT (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req_msg  (req_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg)
  );

  always #(clk_period / 2) clk = ~clk;

  //--------------------
  // Helpers
  //--------------------

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Low word of the full product, same for signed and unsigned
  function automatic logic [31:0] mul_low(input logic [31:0] a, input logic [31:0] b);
    logic [63:0] p;
    p = 64'(a) * 64'(b);
    return p[31:0];
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic report_test(input string name, input int items, input int errs_before);
    tests_run++;
    $display("%s: %0d items, %0d errors", name, items, error_count - errs_before);
  endtask

  // Offers op_a/op_b in order, inputs change 1 ns after the edge
  task automatic send_list(input int n);
    logic accepted;
    for (int i = 0; i < n; i++) begin
      req_val  = 1'b1;
      req_msg  = '{a: op_a[i], b: op_b[i]};
      accepted = 1'b0;
      while (!accepted) begin
        // Mid-cycle value equals value at the next edge
        @(negedge clk);
        accepted = req_rdy;
        @(posedge clk);
        #1;
      end
      expected_q.push_back(mul_low(op_a[i], op_b[i]));
    end
    req_val = 1'b0;
  endtask

  task automatic recv_list(input int n, input logic random_ready);
    int          got;
    logic [31:0] exp_val;
    logic [31:0] draw;
    got = 0;
    while (got < n) begin
      if (random_ready) begin
        draw     = rand_bits(1);
        resp_rdy = draw[0];
      end else begin
        resp_rdy = 1'b1;
      end
      @(negedge clk);
      if (resp_val && resp_rdy) begin
        got++;
        if (expected_q.size() == 0) begin
          error_count++;
          $display("response at %0t ns arrived with no request outstanding", $time);
        end else begin
          exp_val = expected_q.pop_front();
          check_value("resp_msg.result", resp_msg.result, exp_val);
        end
      end
      @(posedge clk);
      #1;
    end
    resp_rdy = 1'b0;
  endtask

  // No extra response and nothing left outstanding
  task automatic check_idle();
    resp_rdy = 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_value("resp_val", 32'(resp_val), 32'd0);
    end
    check_value("pending", 32'(expected_q.size()), 32'd0);
    @(posedge clk);
    #1;
    resp_rdy = 1'b0;
  endtask

  //--------------------
  // Tests
  //--------------------

  task automatic test_reset();
    int errs;
    errs = error_count;
    @(negedge clk);
    check_value("resp_val", 32'(resp_val), 32'd0);
    check_value("req_rdy", 32'(req_rdy), 32'd1);
    @(posedge clk);
    #1;
    report_test("reset state", 0, errs);
  endtask

  task automatic test_directed();
    int errs;
    errs = error_count;
    // Zero, one, all-ones, powers of two, negative times positive
    op_a[0] = 32'h00000000; op_b[0] = 32'h12345678;
    op_a[1] = 32'hdeadbeef; op_b[1] = 32'h00000000;
    op_a[2] = 32'h00000001; op_b[2] = 32'h89abcdef;
    op_a[3] = 32'hffffffff; op_b[3] = 32'h00000001;
    op_a[4] = 32'hffffffff; op_b[4] = 32'hffffffff;
    op_a[5] = 32'h00010000; op_b[5] = 32'h00010000;
    op_a[6] = 32'h80000000; op_b[6] = 32'h00000002;
    op_a[7] = 32'h00000400; op_b[7] = 32'h00200000;
    op_a[8] = 32'hfffffffd; op_b[8] = 32'h00000007;
    op_a[9] = 32'hffff8000; op_b[9] = 32'h00001234;
    fork
      send_list(n_directed);
      recv_list(n_directed, 1'b0);
    join
    check_idle();
    report_test("directed pairs", n_directed, errs);
  endtask

  task automatic test_random(input string name, input int n, input logic random_ready);
    int errs;
    errs = error_count;
    // Operands drawn before the fork keep the LFSR order fixed
    for (int i = 0; i < n; i++) begin
      op_a[i] = rand_bits(32);
      op_b[i] = rand_bits(32);
    end
    fork
      send_list(n);
      recv_list(n, random_ready);
    join
    check_idle();
    report_test(name, n, errs);
  endtask

  // Consumer stalled, request side must back up after five items
  task automatic test_backpressure();
    int          errs;
    int          accepted;
    logic        fired;
    logic [31:0] a;
    logic [31:0] b;
    errs     = error_count;
    accepted = 0;
    resp_rdy = 1'b0;
    a        = rand_bits(32);
    b        = rand_bits(32);
    req_val  = 1'b1;
    req_msg  = '{a: a, b: b};
    repeat (stall_cycles) begin
      @(negedge clk);
      fired = req_rdy;
      @(posedge clk);
      #1;
      if (fired) begin
        accepted++;
        expected_q.push_back(mul_low(a, b));
        a       = rand_bits(32);
        b       = rand_bits(32);
        req_msg = '{a: a, b: b};
      end
    end
    req_val = 1'b0;
    @(negedge clk);
    check_value("req_rdy", 32'(req_rdy), 32'd0);
    check_value("accepted", 32'(accepted), 32'(n_stall_max));
    @(posedge clk);
    #1;
    recv_list(accepted, 1'b0);
    check_idle();
    report_test("output stall", accepted, errs);
  endtask

  //--------------------
  // Main sequence
  //--------------------

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    req_val     = 1'b0;
    req_msg     = '0;
    resp_rdy    = 1'b0;
    lfsr_state  = 32'h367308b2;
    error_count = 0;
    check_count = 0;
    tests_run   = 0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    test_reset();
    test_directed();
    test_random("random back-to-back", n_random, 1'b0);
    test_backpressure();
    test_random("random ready toggle", n_toggle, 1'b1);

    $display("tests %0d, checks %0d, errors %0d", tests_run, check_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Run limit from item count and per-item bound
  initial begin
    #(watchdog_ns);
    $display("timeout at %0t ns, responses stopped arriving", $time);
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- vlog.f
rtl/imul_pkg.sv
rtl/imul_msg_queue.sv
rtl/imul_dpath.sv
rtl/imul_ctrl.sv
rtl/imul_top.sv
tb/imul_tb.sv

//--- Makefile
# Verilator build and run of the multiplier testbench

SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = imul_tb
FILELIST = vlog.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
